//--- Makefile
# Verilator flow for the edge sum compute unit
VERILATOR ?= verilator
TOP       ?= edge_sum_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Finished with no errors
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/edge_sum_cases.txt
// Columns: group scale vertex_id degree ready_stall, then degree pairs of data and weight
// All fields hex, one job per line; a group of 0 ends the list
1 0 0010 3 0    ffff ffff  ffff ffff  0003 0005
1 4 0011 4 0    1234 0056  00ff 0100  8000 0002  0001 0001
1 f 0012 2 0    ffff ffff  7fff 8001
2 3 0100 5 0    0011 0022  0033 0044  0055 0066  0077 0088  0099 00aa
2 3 0101 1 0    abcd 1234
2 0 0102 3 0    0001 0002  0003 0004  0005 0006
2 7 0103 4 0    f00d 0bad  cafe 0001  1111 2222  0fff 0fff
3 1 0200 2 12c  0010 0010  0020 0020
3 1 0201 3 0    0100 0003  0200 0005  0300 0007
3 1 0202 2 0    ffff 0002  0002 ffff
3 1 0203 1 0    4000 4000
3 1 0204 3 0    0009 0009  0008 0008  0007 0007
3 1 0205 2 0    1000 0010  2000 0020
3 1 0206 2 0    00aa 00bb  00cc 00dd
3 1 0207 3 0    0101 0202  0303 0404  0505 0606
3 1 0208 2 0    7777 0002  8888 0003
3 1 0209 1 0    fedc 0001
0 0 0 0 0

//--- bench/edge_sum_checker.sv
// Result checker for the edge sum compute unit
// Counts accepted edges per job and compares each transferred result
// with the expected entry queued by the testbench

`timescale 1ns/100ps
`default_nettype none

module edge_sum_checker #(
	parameter logic [graph_types_pkg::CU_ID_BITS-1:0] CU_ID = 8'h21
) (
	input logic                         clock,
	input logic                         rstn,
	input graph_types_pkg::vertex_job_t job,
	input logic                         job_ready,
	input graph_types_pkg::edge_in_t    edge_data,
	input logic                         edge_ready,
	input graph_types_pkg::result_t     result,
	input logic                         result_valid,
	input logic                         result_ready
);

	import graph_types_pkg::*;

	localparam int ENTRY_BITS = VERTEX_ID_BITS + DEGREE_BITS + SUM_BITS;

	// Expected id, degree and sum, one entry per job in order
	logic [ENTRY_BITS-1:0] expect_q [$];
	int                    edge_counts [$];
	int                    error_count = 0;
	int                    result_count = 0;

	// Result offered but not taken on the last edge
	logic                  held = 1'b0;
	result_t               held_result;

	always @(posedge clock) begin
		logic [ENTRY_BITS-1:0]     expected;
		logic [VERTEX_ID_BITS-1:0] exp_id;
		logic [DEGREE_BITS-1:0]    exp_degree;
		logic [SUM_BITS-1:0]       exp_sum;
		int                        seen;
		if (rstn) begin
			// A held result stays valid and unchanged until taken
			if (held) begin
				if (!result_valid) begin
					error_count++;
					$display("ERROR result_valid expected %h actual %h", 1'b1, result_valid);
				end else if (result !== held_result) begin
					error_count++;
					$display("ERROR result expected %h actual %h", held_result, result);
				end
			end
			if (job.valid && job_ready)
				edge_counts.push_back(0);
			if (edge_data.valid && edge_ready) begin
				if (edge_counts.size() == 0) begin
					error_count++;
					$display("An edge was accepted before any job");
				end else begin
					edge_counts[edge_counts.size()-1]++;
				end
			end
			if (result_valid && result_ready) begin
				result_count++;
				if (expect_q.size() == 0 || edge_counts.size() == 0) begin
					error_count++;
					$display("Result for vertex %h arrived with no job pending", result.index);
				end else begin
					expected   = expect_q.pop_front();
					seen       = edge_counts.pop_front();
					exp_id     = expected[ENTRY_BITS-1 -: VERTEX_ID_BITS];
					exp_degree = expected[SUM_BITS +: DEGREE_BITS];
					exp_sum    = expected[SUM_BITS-1:0];
					if (result.index !== exp_id) begin
						error_count++;
						$display("ERROR result.index expected %h actual %h",
							exp_id, result.index);
					end
					if (result.cu_id !== CU_ID) begin
						error_count++;
						$display("ERROR result.cu_id expected %h actual %h",
							CU_ID, result.cu_id);
					end
					if (result.sum !== exp_sum) begin
						error_count++;
						$display("ERROR result.sum expected %h actual %h",
							exp_sum, result.sum);
					end
					if (seen != int'(exp_degree)) begin
						error_count++;
						$display("ERROR edge_ready accepted edges expected %h actual %h",
							exp_degree, seen);
					end
				end
			end
			held        = result_valid && !result_ready;
			held_result = result;
		end else begin
			held = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- bench/edge_sum_tb.sv
// Testbench for the edge sum compute unit
// Reads jobs and edges from the cases file, drives APB, jobs and edges,
// and throttles result_ready; the checker compares every result

`timescale 1ns/100ps
`default_nettype none

module edge_sum_tb;

	import graph_types_pkg::*;
	import sum_control_pkg::*;

	localparam int                    FIFO_DEPTH = 8;
	localparam logic [CU_ID_BITS-1:0] CU_ID      = 8'h21;
	localparam int                    TIMEOUT    = 2000;
	localparam int                    RUN_LIMIT  = 50000;
	localparam int                    CASE_WORDS = 512;
	localparam logic [31:0]           SEED       = 32'h5c09;

	logic        clock;
	logic        rstn;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	vertex_job_t job;
	logic        job_ready;
	edge_in_t    edge_data;
	logic        edge_ready;
	result_t     result;
	logic        result_valid;
	logic        result_ready;

	logic [31:0] cases [CASE_WORDS];
	logic [31:0] gap_state;
	logic [31:0] ready_state;
	int          cycle = 0;
	int          stall_until = 0;
	int          blocked_cycles = 0;
	int          tb_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          total_edges = 0;
	int          jobs_sent = 0;
	bit          timeout_hit = 1'b0;
	bit          run_done = 1'b0;

	edge_sum_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CU_ID     (CU_ID     )
	) u_edge_sum_top (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.apb_req     (apb_req     ),
		.apb_rsp     (apb_rsp     ),
		.job         (job         ),
		.job_ready   (job_ready   ),
		.edge_data   (edge_data   ),
		.edge_ready  (edge_ready  ),
		.result      (result      ),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	edge_sum_checker #(
		.CU_ID(CU_ID)
	) u_checker (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.job         (job         ),
		.job_ready   (job_ready   ),
		.edge_data   (edge_data   ),
		.edge_ready  (edge_ready  ),
		.result      (result      ),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (edge_data.valid && !edge_ready)
			blocked_cycles <= blocked_cycles + 1;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_rand(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reference term of one edge: unsigned product, shifted right
	function automatic logic [31:0] edge_term(input logic [15:0] data,
			input logic [15:0] weight, input logic [3:0] scale);
		logic [31:0] product;
		product = data * weight;
		return product >> scale;
	endfunction

	function automatic int error_total();
		return tb_errors + u_checker.error_count;
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
		timeout_hit = 1'b1;
		forever @(posedge clock);
	endtask

	task automatic close_test(input string name, input int errors_before);
		if (error_total() == errors_before) begin
			tests_passed++;
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s", name);
		end
	endtask

	// Random result_ready, held low during a stall window
	always @(negedge clock) begin
		ready_state = next_rand(ready_state);
		if (!rstn || cycle < stall_until)
			result_ready = 1'b0;
		else
			result_ready = (ready_state[17:16] != 2'b00);
	end

	////////////////////////////////////////
	// APB access, setup then access phase
	////////////////////////////////////////

	// Zero wait states, so every access is exactly two cycles
	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, input bit expect_err, output logic [31:0] rdata);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clock);
		apb_req.penable = 1'b1;
		@(negedge clock);
		if (!apb_rsp.pready) begin
			tb_errors++;
			$display("ERROR apb_rsp.pready at address %h expected %h actual %h",
				addr, 1'b1, apb_rsp.pready);
		end
		rdata = apb_rsp.prdata;
		if (apb_rsp.pslverr != expect_err) begin
			tb_errors++;
			$display("ERROR apb_rsp.pslverr at address %h expected %h actual %h",
				addr, expect_err, apb_rsp.pslverr);
		end
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
			input bit expect_err);
		logic [31:0] unused;
		apb_access(1'b1, addr, wdata, expect_err, unused);
	endtask

	task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] expected,
			input bit expect_err);
		logic [31:0] rdata;
		apb_access(1'b0, addr, '0, expect_err, rdata);
		if (!expect_err && rdata !== expected) begin
			tb_errors++;
			$display("ERROR apb_rsp.prdata at address %h expected %h actual %h",
				addr, expected, rdata);
		end
	endtask

	////////////////////////////////////////
	// Job and edge drivers
	////////////////////////////////////////

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (!job_ready) begin
			if (waited == TIMEOUT)
				stop_on_timeout("job_ready");
			@(negedge clock);
			waited++;
		end
	endtask

	task automatic send_job(input logic [15:0] id, input logic [11:0] degree);
		job.valid  = 1'b1;
		job.id     = id;
		job.degree = degree;
		wait_idle();
		@(negedge clock);
		job.valid = 1'b0;
	endtask

	task automatic send_edge(input logic [15:0] data, input logic [15:0] weight);
		int waited;
		gap_state = next_rand(gap_state);
		repeat (int'(gap_state[29:28])) @(negedge clock);
		edge_data.valid  = 1'b1;
		edge_data.data   = data;
		edge_data.weight = weight;
		waited = 0;
		while (!edge_ready) begin
			if (waited == TIMEOUT)
				stop_on_timeout("edge_ready");
			@(negedge clock);
			waited++;
		end
		@(negedge clock);
		edge_data.valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (u_checker.expect_q.size() != 0) begin
			if (waited == TIMEOUT)
				stop_on_timeout("all results to be delivered");
			@(negedge clock);
			waited++;
		end
	endtask

	// Hand one job to the checker and drive it, then step past its record
	task automatic run_case(inout int p, inout bit needs_block);
		logic [3:0]  scale;
		logic [15:0] id;
		logic [11:0] degree;
		logic [31:0] stall;
		logic [31:0] sum;
		int          i;
		scale  = cases[p+1][3:0];
		id     = cases[p+2][15:0];
		degree = cases[p+3][11:0];
		stall  = cases[p+4];
		p      = p + 5;
		// Scale must not move under edges still in the pipeline
		wait_idle();
		apb_write(SCALE, 32'(scale), 1'b0);
		if (stall != 0) begin
			stall_until = cycle + int'(stall);
			needs_block = 1'b1;
		end
		sum = '0;
		for (i = 0; i < int'(degree); i++)
			sum = sum + edge_term(cases[p+2*i][15:0], cases[p+2*i+1][15:0], scale);
		u_checker.expect_q.push_back({id, degree, sum});
		total_edges += int'(degree);
		jobs_sent++;
		send_job(id, degree);
		for (i = 0; i < int'(degree); i++)
			send_edge(cases[p+2*i][15:0], cases[p+2*i+1][15:0]);
		p = p + 2 * int'(degree);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic register_test();
		int errors_before;
		int i;
		errors_before = error_total();
		apb_read_check(CTRL, 32'h0, 1'b0);
		apb_read_check(SCALE, 32'h0, 1'b0);
		apb_read_check(EDGE_COUNT, 32'h0, 1'b0);
		apb_read_check(RESULT_COUNT, 32'h0, 1'b0);
		// Offer a job and an edge while disabled
		job.valid       = 1'b1;
		job.id          = 16'h0bad;
		job.degree      = 12'h1;
		edge_data.valid = 1'b1;
		for (i = 0; i < 8; i++) begin
			@(negedge clock);
			if (job_ready || edge_ready) begin
				tb_errors++;
				$display("ERROR job_ready/edge_ready expected 0/0 actual %h/%h",
					job_ready, edge_ready);
			end
			if (result_valid) begin
				tb_errors++;
				$display("ERROR result_valid expected 0 actual %h", result_valid);
			end
		end
		job.valid       = 1'b0;
		edge_data.valid = 1'b0;
		apb_write(SCALE, 32'h9, 1'b0);
		apb_read_check(SCALE, 32'h9, 1'b0);
		apb_write(EDGE_COUNT, 32'h55, 1'b1);
		apb_read_check(EDGE_COUNT, 32'h0, 1'b0);
		apb_read_check(8'h10, 32'h0, 1'b1);
		apb_write(CTRL, 32'h1, 1'b0);
		apb_read_check(CTRL, 32'h1, 1'b0);
		apb_write(CTRL, 32'h0, 1'b0);
		apb_read_check(CTRL, 32'h0, 1'b0);
		apb_write(SCALE, 32'h0, 1'b0);
		close_test("register access", errors_before);
	endtask

	task automatic enable_test();
		logic [15:0] data [6];
		logic [15:0] weight [6];
		logic [31:0] sum;
		int          errors_before;
		int          i;
		errors_before = error_total();
		sum = '0;
		for (i = 0; i < 6; i++) begin
			data[i]   = 16'h0100 + 16'(i) * 16'h0111;
			weight[i] = 16'h0040 + 16'(i);
			sum       = sum + edge_term(data[i], weight[i], 4'd2);
		end
		wait_idle();
		apb_write(SCALE, 32'h2, 1'b0);
		u_checker.expect_q.push_back({16'h0300, 12'd6, sum});
		total_edges += 6;
		jobs_sent++;
		send_job(16'h0300, 12'd6);
		for (i = 0; i < 3; i++)
			send_edge(data[i], weight[i]);
		apb_write(CTRL, 32'h0, 1'b0);
		edge_data.valid  = 1'b1;
		edge_data.data   = data[3];
		edge_data.weight = weight[3];
		for (i = 0; i < 10; i++) begin
			@(negedge clock);
			if (edge_ready) begin
				tb_errors++;
				$display("ERROR edge_ready expected 0 actual %h", edge_ready);
			end
		end
		edge_data.valid = 1'b0;
		apb_write(CTRL, 32'h1, 1'b0);
		for (i = 3; i < 6; i++)
			send_edge(data[i], weight[i]);
		wait_drain();
		close_test("enable cleared and set within a job", errors_before);
	endtask

	task automatic counter_test();
		int errors_before;
		errors_before = error_total();
		apb_read_check(EDGE_COUNT, 32'(total_edges), 1'b0);
		apb_read_check(RESULT_COUNT, 32'(u_checker.result_count), 1'b0);
		if (u_checker.result_count != jobs_sent) begin
			tb_errors++;
			$display("ERROR result_count expected %h actual %h",
				jobs_sent, u_checker.result_count);
		end
		close_test("edge and result counters", errors_before);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int p;
		int group;
		int jobs;
		int errors_before;
		int blocked_before;
		bit needs_block;
		rstn         = 1'b0;
		apb_req      = '0;
		job          = '0;
		edge_data    = '0;
		result_ready = 1'b0;
		gap_state    = SEED;
		ready_state  = next_rand(SEED);
		$readmemh("bench/edge_sum_cases.txt", cases);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		register_test();
		apb_write(CTRL, 32'h1, 1'b0);
		p = 0;
		while (cases[p] != 0) begin
			group          = int'(cases[p]);
			jobs           = 0;
			needs_block    = 1'b0;
			blocked_before = blocked_cycles;
			errors_before  = error_total();
			while (cases[p] == 32'(group)) begin
				run_case(p, needs_block);
				jobs++;
			end
			wait_drain();
			if (needs_block && blocked_cycles == blocked_before) begin
				tb_errors++;
				$display("edge_ready never dropped while results were held back");
			end
			close_test($sformatf("case group %0d with %0d jobs", group, jobs), errors_before);
		end
		enable_test();
		counter_test();
		run_done = 1'b1;
	end

	// Run limit and final report
	initial begin
		while (!run_done && !timeout_hit && cycle < RUN_LIMIT)
			@(negedge clock);
		if (!run_done && !timeout_hit)
			$display("Run stopped after %0d cycles without finishing", RUN_LIMIT);
		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, error_total());
		if (run_done && error_total() == 0 && tests_failed == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/graph_types_pkg.sv
hdl/sum_control_pkg.sv
hdl/sync_fifo.sv
hdl/sum_csr_apb.sv
hdl/edge_sum_kernel.sv
hdl/edge_sum_top.sv
bench/edge_sum_checker.sv
bench/edge_sum_tb.sv

//--- hdl/edge_sum_kernel.sv
// Edge sum kernel
// Takes one vertex job, multiplies data by weight on each edge,
// shifts by the configured scale and accumulates into a 32-bit sum
// Each finished sum is queued with the vertex id and unit identity

`timescale 1ns/100ps
`default_nettype none

module edge_sum_kernel #(
	parameter logic [graph_types_pkg::CU_ID_BITS-1:0] CU_ID      = 8'h21,
	parameter int                                     FIFO_DEPTH = 8
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  sum_control_pkg::kernel_cfg_t cfg,
	input  graph_types_pkg::vertex_job_t job,
	output logic                         job_ready,
	input  graph_types_pkg::edge_in_t    edge_data,
	output logic                         edge_ready,
	output graph_types_pkg::result_t     result,
	output logic                         result_valid,
	input  logic                         result_ready,
	output logic                         edge_taken,
	output logic                         result_taken
);

	import graph_types_pkg::*;
	import sum_control_pkg::*;

	kernel_state_e             state;
	logic [VERTEX_ID_BITS-1:0] job_id;
	logic [DEGREE_BITS-1:0]    remaining;
	logic                      job_fire;
	logic                      edge_fire;
	logic                      s1_valid;
	logic                      s2_valid;
	logic                      s3_valid;
	logic [DATA_BITS-1:0]      s1_data;
	logic [DATA_BITS-1:0]      s1_weight;
	logic [SUM_BITS-1:0]       product;
	logic [SUM_BITS-1:0]       scaled;
	logic [SUM_BITS-1:0]       sum;
	logic                      pipe_empty;
	logic                      push;
	result_t                   push_data;
	logic                      q_full;
	logic                      q_alfull;
	logic                      q_empty;
	logic                      pop;

	////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////

	assign job_ready  = (state == IDLE) & cfg.enable;
	// Hold edges back while the queue has only one slot left
	assign edge_ready = (state == ACCUM) & cfg.enable & ~q_alfull;
	assign job_fire   = job.valid & job_ready;
	assign edge_fire  = edge_data.valid & edge_ready;
	assign edge_taken = edge_fire;

	////////////////////////////////////////
	// Job FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			remaining <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (job_fire) begin
						state     <= ACCUM;
						remaining <= job.degree;
					end
				end
				ACCUM: begin
					if (edge_fire) begin
						remaining <= remaining - 1'b1;
						if (remaining == DEGREE_BITS'(1))
							state <= DRAIN;
					end
				end
				DRAIN: begin
					if (push)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (job_fire)
			job_id <= job.id;
	end

	////////////////////////////////////////
	// Multiply, scale, accumulate
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else begin
			s1_valid <= edge_fire;
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (edge_fire) begin
			s1_data   <= edge_data.data;
			s1_weight <= edge_data.weight;
		end
		if (s1_valid)
			product <= s1_data * s1_weight;
		// Scale is sampled as the edge passes this stage
		if (s2_valid)
			scaled <= product >> cfg.scale;
	end

	// Sum wraps modulo 2^32, cleared once queued
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			sum <= '0;
		else if (push)
			sum <= '0;
		else if (s3_valid)
			sum <= sum + scaled;
	end

	////////////////////////////////////////
	// Result queue
	////////////////////////////////////////

	assign pipe_empty = ~(s1_valid | s2_valid | s3_valid);
	assign push       = (state == DRAIN) & pipe_empty & ~q_full;

	assign push_data.index = job_id;
	assign push_data.cu_id = CU_ID;
	assign push_data.sum   = sum;

	sync_fifo #(
		.WIDTH($bits(result_t)),
		.DEPTH(FIFO_DEPTH)
	) u_result_fifo (
		.clock   (clock    ),
		.rstn    (rstn     ),
		.push    (push     ),
		.data_in (push_data),
		.full    (q_full   ),
		.alfull  (q_alfull ),
		.pop     (pop      ),
		.data_out(result   ),
		.empty   (q_empty  )
	);

	assign result_valid = ~q_empty;
	assign pop          = result_valid & result_ready;
	assign result_taken = pop;

	// Zero-degree jobs would hang the FSM in ACCUM
	job_degree_nonzero: assert property (@(posedge clock) disable iff (!rstn)
		job_fire |-> (job.degree != '0))
		else $error("Vertex job accepted with zero edges");

endmodule

`default_nettype wire

//--- hdl/edge_sum_top.sv
// Edge sum compute unit
// APB register block beside the edge sum kernel and its result queue

`timescale 1ns/100ps
`default_nettype none

module edge_sum_top #(
	parameter int                                     FIFO_DEPTH = 8,
	parameter logic [graph_types_pkg::CU_ID_BITS-1:0] CU_ID      = 8'h21
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  sum_control_pkg::apb_req_t    apb_req,
	output sum_control_pkg::apb_rsp_t    apb_rsp,
	input  graph_types_pkg::vertex_job_t job,
	output logic                         job_ready,
	input  graph_types_pkg::edge_in_t    edge_data,
	output logic                         edge_ready,
	output graph_types_pkg::result_t     result,
	output logic                         result_valid,
	input  logic                         result_ready
);

	import sum_control_pkg::*;

	kernel_cfg_t cfg;
	logic        edge_taken;
	logic        result_taken;

	sum_csr_apb u_sum_csr_apb (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.apb_req     (apb_req     ),
		.apb_rsp     (apb_rsp     ),
		.cfg         (cfg         ),
		.edge_taken  (edge_taken  ),
		.result_taken(result_taken)
	);

	edge_sum_kernel #(
		.CU_ID     (CU_ID     ),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_edge_sum_kernel (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.cfg         (cfg         ),
		.job         (job         ),
		.job_ready   (job_ready   ),
		.edge_data   (edge_data   ),
		.edge_ready  (edge_ready  ),
		.result      (result      ),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.edge_taken  (edge_taken  ),
		.result_taken(result_taken)
	);

endmodule

`default_nettype wire

//--- hdl/graph_types_pkg.sv
// Graph data types for the edge sum compute unit
// Field widths and the edge, vertex job and result records

`default_nettype none

package graph_types_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	parameter int VERTEX_ID_BITS = 16;
	parameter int DATA_BITS      = 16;
	parameter int SUM_BITS       = 32;
	parameter int DEGREE_BITS    = 12;
	parameter int CU_ID_BITS     = 8;

	////////////////////////////////////////
	// Records
	////////////////////////////////////////

	// One edge of the current vertex
	typedef struct packed {
		logic                 valid;
		logic [DATA_BITS-1:0] data;
		logic [DATA_BITS-1:0] weight;
	} edge_in_t;

	// Vertex job, degree is the number of edges that follow
	typedef struct packed {
		logic                      valid;
		logic [VERTEX_ID_BITS-1:0] id;
		logic [DEGREE_BITS-1:0]    degree;
	} vertex_job_t;

	// Finished vertex sum
	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0] index;
		logic [CU_ID_BITS-1:0]     cu_id;
		logic [SUM_BITS-1:0]       sum;
	} result_t;

endpackage

`default_nettype wire

//--- hdl/sum_control_pkg.sv
// Control types for the edge sum compute unit
// APB bus records, register map, kernel FSM states and configuration

`default_nettype none

package sum_control_pkg;

	parameter int APB_ADDR_BITS = 8;
	parameter int APB_DATA_BITS = 32;
	parameter int SCALE_BITS    = 4;

	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [APB_ADDR_BITS-1:0] paddr;
		logic [APB_DATA_BITS-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DATA_BITS-1:0] prdata;
		logic                     pready;
		logic                     pslverr;
	} apb_rsp_t;

	// Register map, both counters are read only
	typedef enum logic [APB_ADDR_BITS-1:0] {
		CTRL         = 8'h00,
		SCALE        = 8'h04,
		EDGE_COUNT   = 8'h08,
		RESULT_COUNT = 8'h0C
	} csr_addr_e;

	typedef enum logic [1:0] {IDLE, ACCUM, DRAIN} kernel_state_e;

	typedef struct packed {
		logic                  enable;
		logic [SCALE_BITS-1:0] scale;
	} kernel_cfg_t;

endpackage

`default_nettype wire

//--- hdl/sum_csr_apb.sv
// Edge sum register block
// APB slave with zero wait states, holds enable and scale shift
// and counts consumed edges and delivered results

`timescale 1ns/100ps
`default_nettype none

module sum_csr_apb (
	input  logic                         clock,
	input  logic                         rstn,
	input  sum_control_pkg::apb_req_t    apb_req,
	output sum_control_pkg::apb_rsp_t    apb_rsp,
	output sum_control_pkg::kernel_cfg_t cfg,
	input  logic                         edge_taken,
	input  logic                         result_taken
);

	import sum_control_pkg::*;

	csr_addr_e                addr;
	logic                     access;
	logic                     addr_hit;
	logic                     read_only;
	logic                     wr_ok;
	logic                     enable;
	logic [SCALE_BITS-1:0]    scale;
	logic [APB_DATA_BITS-1:0] edge_count;
	logic [APB_DATA_BITS-1:0] result_count;
	logic [APB_DATA_BITS-1:0] rdata;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign addr   = csr_addr_e'(apb_req.paddr);
	assign access = apb_req.psel & apb_req.penable;

	always_comb begin
		addr_hit  = 1'b1;
		read_only = 1'b0;
		rdata     = '0;
		case (addr)
			CTRL: rdata[0] = enable;
			SCALE: rdata[SCALE_BITS-1:0] = scale;
			EDGE_COUNT: begin
				rdata     = edge_count;
				read_only = 1'b1;
			end
			RESULT_COUNT: begin
				rdata     = result_count;
				read_only = 1'b1;
			end
			default: addr_hit = 1'b0;
		endcase
	end

	// Writes land at the end of the access phase
	assign wr_ok = access & apb_req.pwrite & addr_hit & ~read_only;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable <= 1'b0;
			scale  <= '0;
		end else if (wr_ok) begin
			if (addr == CTRL)
				enable <= apb_req.pwdata[0];
			if (addr == SCALE)
				scale <= apb_req.pwdata[SCALE_BITS-1:0];
		end
	end

	////////////////////////////////////////
	// Event counters
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count   <= '0;
			result_count <= '0;
		end else begin
			if (edge_taken)
				edge_count <= edge_count + 1'b1;
			if (result_taken)
				result_count <= result_count + 1'b1;
		end
	end

	assign apb_rsp.prdata  = (access & ~apb_req.pwrite & addr_hit) ? rdata : '0;
	assign apb_rsp.pready  = access;
	assign apb_rsp.pslverr = access & (~addr_hit | (apb_req.pwrite & read_only));

	assign cfg.enable = enable;
	assign cfg.scale  = scale;

	// Master must hold psel through the access phase
	penable_needs_psel: assert property (@(posedge clock) disable iff (!rstn)
		apb_req.penable |-> apb_req.psel)
		else $error("APB penable high without psel");

endmodule

`default_nettype wire

//--- hdl/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with occupancy count, full, almost-full and empty flags
// Head entry is visible on data_out while not empty

`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             alfull,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	assign alfull   = (count >= CNT_BITS'(DEPTH - 1));

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full)
		else $error("FIFO push while full");

	no_pop_when_empty: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> !empty)
		else $error("FIFO pop while empty");

endmodule

`default_nettype wire
